// ==== sim.f ====
common/spinn_rx_pkg.sv
spinn_rx/nrz_2of7_decoder.sv
spinn_rx/pkt_assembler.sv
spinn_rx/pkt_out_reg.sv
spinn_rx/spinn_rx_ctrl.sv
source/spinn_rx_top.sv
dv/spinn_rx_tb.sv

// ==== Makefile ====
# Verilator flow for the SpiNNaker link receiver

VERILATOR  ?= verilator
TOP        ?= spinn_rx_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/spinn_rx_tb.sv ====
// SpiNNaker link receiver testbench driving the 2-of-7 link and checking output packets
module spinn_rx_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import spinn_rx_pkg::*;

  localparam link_t EOP_WIRES   = 7'b110_0000;  // wires 5 and 6
  localparam link_t BAD_WIRES   = 7'b000_0111;  // three wires, never legal
  localparam int    ACK_TIMEOUT = 64;           // covers the 32-cycle forced ack
  localparam int    PKT_TIMEOUT = 16;

  logic  clk;
  logic  rst;
  logic  enable;
  link_t data_2of7;
  logic  ack;
  pkt_t  pkt_data;
  logic  pkt_vld;
  logic  pkt_rdy;
  logic  err;

  pkt_t    rx_pkts [$];  // every transfer seen on the output port
  nibble_t nibs [18];    // current packet in send order
  int      n_nibs;
  pkt_t    exp_frame;

  spinn_rx_top #(.ERR_TIMEOUT(31)) i_dut (
    .clk(clk), .rst(rst), .enable(enable), .data_2of7(data_2of7), .ack(ack),
    .pkt_data(pkt_data), .pkt_vld(pkt_vld), .pkt_rdy(pkt_rdy), .err(err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns
  end

  // log every accepted packet
  always @(posedge clk) begin
    if (!rst && pkt_vld && pkt_rdy)
      rx_pkts.push_back(pkt_data);
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [71:0] got, input logic [71:0] exp);
    assert (got == exp) else
      abort_run($sformatf("[FAIL] %s got %0h expected %0h", name, got, exp));
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  // 2-of-7 transition pattern of a nibble from the link code table
  function automatic link_t code_of(input nibble_t n);
    link_t c;
    if (n < 4'd12)
      c = (7'd1 << (4 + n / 4)) | (7'd1 << (n % 4));  // one upper and one lower wire
    else if (n == 4'd15)
      c = 7'b000_1001;  // wraps round the lower wires
    else
      c = 7'b000_0011 << (n - 4'd12);
    return c;
  endfunction

  task automatic put_code(input link_t code);
    data_2of7 = data_2of7 ^ code;  // NRZ toggles the symbol's wires
  endtask

  task automatic wait_ack_toggle(input logic old_ack, input string what);
    int n;
    n = 0;
    while (ack === old_ack) begin
      step_cycle();
      n++;
      assert (n <= ACK_TIMEOUT) else abort_run({"ack never toggled for ", what});
    end
  endtask

  task automatic send_symbol(input link_t code);
    logic old_ack;
    old_ack = ack;
    put_code(code);
    wait_ack_toggle(old_ack, "a link symbol");
  endtask

  // random nibbles where bit 1 of the first picks the length
  task automatic build_packet(input bit is_long);
    n_nibs    = is_long ? 18 : 10;
    exp_frame = '0;
    for (int i = 0; i < n_nibs; i++) begin
      nibs[i] = nibble_t'($urandom);
      if (i == 0)
        nibs[i][1] = is_long;
      exp_frame[4*i +: 4] = nibs[i];  // first symbol lowest and short leaves top 32 at 0
    end
  endtask

  task automatic send_nibbles(input int from, input int to);
    for (int i = from; i < to; i++)
      send_symbol(code_of(nibs[i]));
  endtask

  task automatic send_packet(input bit is_long);
    build_packet(is_long);
    send_nibbles(0, n_nibs);
    send_symbol(EOP_WIRES);
  endtask

  task automatic expect_packet(input pkt_t exp);
    int n;
    n = 0;
    while (rx_pkts.size() == 0) begin
      step_cycle();
      n++;
      assert (n <= PKT_TIMEOUT) else abort_run("no packet came out of the output port");
    end
    check_eq("pkt_data", rx_pkts.pop_front(), exp);
  endtask

  task automatic check_quiet(input int cycles);
    repeat (cycles) step_cycle();
    assert (rx_pkts.size() == 0) else abort_run("a packet came out that should not have");
  endtask

  task automatic wait_err(input logic level);
    int n;
    n = 0;
    while (err !== level) begin
      step_cycle();
      n++;
      assert (n <= 8) else abort_run("err did not reach the expected level");
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic check_reset();
    repeat (5) begin
      step_cycle();
      check_eq("ack", ack, 0);
      check_eq("pkt_vld", pkt_vld, 0);
      check_eq("err", err, 0);
    end
    rst = 1'b0;
    step_cycle();
    check_eq("ack", ack, 1);  // link_init on the first cycle
  endtask

  task automatic short_and_long();
    send_packet(1'b0);
    expect_packet(exp_frame);
    send_packet(1'b1);
    expect_packet(exp_frame);
    check_quiet(8);
    check_eq("err", err, 0);
  endtask

  task automatic back_pressure();
    pkt_t held;
    logic old_ack;
    pkt_rdy = 1'b0;
    send_packet(1'b0);  // fills the output register and stalls
    held = exp_frame;
    build_packet(1'b1);
    send_nibbles(0, n_nibs);  // data still flows while blocked
    old_ack = ack;
    put_code(EOP_WIRES);
    repeat (20) begin
      step_cycle();
      check_eq("ack", ack, old_ack);
      check_eq("pkt_vld", pkt_vld, 1);
      check_eq("pkt_data", pkt_data, held);
    end
    pkt_rdy = 1'b1;
    wait_ack_toggle(old_ack, "the held eop");
    expect_packet(held);
    expect_packet(exp_frame);
    check_quiet(8);
  endtask

  task automatic wrong_length();
    build_packet(1'b0);
    send_nibbles(0, 7);
    send_symbol(EOP_WIRES);  // acked but dropped
    check_quiet(10);
    check_eq("pkt_vld", pkt_vld, 0);
    send_packet(1'b1);
    expect_packet(exp_frame);
  endtask

  task automatic bad_symbol();
    build_packet(1'b1);
    send_nibbles(0, 4);
    send_symbol(BAD_WIRES);
    wait_err(1'b1);
    send_nibbles(4, 6);  // swallowed while in error
    wait_ack_toggle(ack, "the forced ack in error");  // no symbol pending here
    check_eq("err", err, 1);
    send_symbol(EOP_WIRES);
    wait_err(1'b0);
    check_quiet(10);
    send_packet(1'b0);
    expect_packet(exp_frame);
    check_eq("err", err, 0);
  endtask

  task automatic enable_low();
    logic old_ack;
    send_packet(1'b0);
    expect_packet(exp_frame);
    enable = 1'b0;
    repeat (2) step_cycle();
    build_packet(1'b1);
    old_ack = ack;
    put_code(code_of(nibs[0]));  // parked so it must not be taken
    repeat (20) begin
      step_cycle();
      check_eq("ack", ack, old_ack);
    end
    enable = 1'b1;
    wait_ack_toggle(old_ack, "the first symbol after enable");
    send_nibbles(1, n_nibs);
    send_symbol(EOP_WIRES);
    expect_packet(exp_frame);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst       = 1'b1;
    enable    = 1'b1;
    data_2of7 = '0;
    pkt_rdy   = 1'b1;
    void'($urandom(32'h5b52_8d6e));
    check_reset();
    short_and_long();
    back_pressure();
    wrong_length();
    bad_symbol();
    enable_low();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== source/spinn_rx_top.sv ====
// spinn_rx_top: SpiNNaker link receiver, 2-of-7 link in, valid/ready packets out
module spinn_rx_top #(
  parameter int unsigned ERR_TIMEOUT = 31  // forced ack period in error, minus one
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                enable,
  input  spinn_rx_pkg::link_t data_2of7,
  output logic                ack,
  output spinn_rx_pkg::pkt_t  pkt_data,
  output logic                pkt_vld,
  input  logic                pkt_rdy,
  output logic                err
);
  import spinn_rx_pkg::*;

  // ------------------------------
  // internal nets
  // ------------------------------
  sym_t sym;
  pkt_t frame;
  logic sym_take;
  logic link_init;
  logic shift_en;
  logic first;
  logic load;
  logic exp_eop;
  logic busy;

  spinn_rx_ctrl #(
    .ERR_TIMEOUT (ERR_TIMEOUT)
  ) i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .sym       (sym),
    .exp_eop   (exp_eop),
    .busy      (busy),
    .sym_take  (sym_take),
    .link_init (link_init),
    .shift_en  (shift_en),
    .first     (first),
    .load      (load),
    .err       (err)
  );

  nrz_2of7_decoder i_dec (
    .clk       (clk),
    .rst       (rst),
    .data_2of7 (data_2of7),
    .sym_take  (sym_take),
    .link_init (link_init),
    .sym       (sym),
    .ack       (ack)
  );

  pkt_assembler i_asm (
    .clk      (clk),
    .rst      (rst),
    .sym      (sym),
    .shift_en (shift_en),
    .first    (first),
    .frame    (frame),
    .exp_eop  (exp_eop)
  );

  pkt_out_reg i_out (
    .clk      (clk),
    .rst      (rst),
    .frame    (frame),
    .load     (load),
    .pkt_rdy  (pkt_rdy),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .busy     (busy)
  );

endmodule

// ==== spinn_rx/spinn_rx_ctrl.sv ====
// spinn_rx_ctrl: receive FSM deciding symbol takes, packet loads, error timeout and err status
module spinn_rx_ctrl #(
  parameter int unsigned ERR_TIMEOUT = 31  // cycles between forced acks in error
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  spinn_rx_pkg::sym_t sym,
  input  logic               exp_eop,
  input  logic               busy,
  output logic               sym_take,
  output logic               link_init,
  output logic               shift_en,
  output logic               first,
  output logic               load,
  output logic               err
);
  import spinn_rx_pkg::*;

  localparam int CNT_W = $clog2(ERR_TIMEOUT + 1);

  typedef enum logic [2:0] {
    ST_REST,  // first cycle out of reset
    ST_PARK,  // link frozen, enable low
    ST_IDLE,  // waiting for first symbol
    ST_TRAN,  // collecting data symbols
    ST_EOP,   // eop seen, length check
    ST_WTRD,  // good packet, output blocked
    ST_ERR    // dropping until eop
  } state_t;

  state_t           state;
  state_t           state_nxt;
  logic [CNT_W-1:0] err_cnt;
  logic             err_tmo;

  assign err_tmo = (err_cnt == '0);

  // where to go once a packet is finished
  function automatic state_t after_pkt(input logic en);
    return en ? ST_IDLE : ST_PARK;
  endfunction

  // ------------------------------
  // next state and strobes
  // ------------------------------
  always_comb begin
    state_nxt = state;
    sym_take  = 1'b0;
    link_init = 1'b0;
    shift_en  = 1'b0;
    first     = 1'b0;
    load      = 1'b0;
    case (state)
      ST_REST: begin
        link_init = 1'b1;  // latch wires, ack goes to 1
        state_nxt = after_pkt(enable);
      end
      ST_PARK: begin
        if (enable) state_nxt = ST_IDLE;
      end
      ST_IDLE: begin
        if (!enable) begin
          state_nxt = ST_PARK;  // nothing in flight, park now
        end else if (sym.nsb) begin
          sym_take = 1'b1;  // eop between packets just gets acked
          if (sym.dat) begin
            shift_en  = 1'b1;
            first     = 1'b1;
            state_nxt = ST_TRAN;
          end else if (sym.bad) begin
            state_nxt = ST_ERR;
          end
        end
      end
      ST_TRAN: begin
        if (sym.dat) begin
          sym_take = 1'b1;
          shift_en = 1'b1;
        end else if (sym.bad) begin
          sym_take  = 1'b1;
          state_nxt = ST_ERR;
        end else if (sym.eop) begin
          state_nxt = ST_EOP;  // ack deferred to the length check
        end
      end
      ST_EOP: begin
        if (!busy) begin
          sym_take  = 1'b1;
          load      = exp_eop;  // wrong length is dropped silently
          state_nxt = after_pkt(enable);
        end else if (exp_eop) begin
          state_nxt = ST_WTRD;
        end
      end
      ST_WTRD: begin
        if (!busy) begin
          sym_take  = 1'b1;  // eop ack released with the load
          load      = 1'b1;
          state_nxt = after_pkt(enable);
        end
      end
      ST_ERR: begin
        sym_take = sym.nsb | err_tmo;  // timeout unsticks a hung sender
        if (sym.eop) state_nxt = after_pkt(enable);
      end
      default: state_nxt = ST_REST;
    endcase
  end

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= ST_REST;
      err     <= 1'b0;
      err_cnt <= CNT_W'(ERR_TIMEOUT);
    end else begin
      state <= state_nxt;
      err   <= (state == ST_ERR);  // lags the state by one cycle
      if (state == ST_ERR && !err_tmo)
        err_cnt <= err_cnt - 1'b1;
      else
        err_cnt <= CNT_W'(ERR_TIMEOUT);  // reload on wrap or outside error
    end
  end

  // decoder must classify each change one way only
  a_sym_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({sym.dat, sym.eop, sym.bad}));

  // output register never overwritten while a packet is pending
  a_no_load_busy: assert property (@(posedge clk) disable iff (rst)
    load |-> !busy);

endmodule

// ==== spinn_rx/pkt_out_reg.sv ====
// pkt_out_reg: output packet register holding valid until the consumer accepts it
module pkt_out_reg (
  input  logic               clk,
  input  logic               rst,
  input  spinn_rx_pkg::pkt_t frame,
  input  logic               load,
  input  logic               pkt_rdy,
  output spinn_rx_pkg::pkt_t pkt_data,
  output logic               pkt_vld,
  output logic               busy
);
  import spinn_rx_pkg::*;

  logic vld_pend;  // data loaded, valid follows next cycle

  always_ff @(posedge clk) begin
    if (load)
      pkt_data <= frame;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_pend <= 1'b0;
      pkt_vld  <= 1'b0;
    end else begin
      vld_pend <= load;
      if (vld_pend)
        pkt_vld <= 1'b1;
      else if (pkt_rdy)
        pkt_vld <= 1'b0;  // accepted
    end
  end

  assign busy = pkt_vld & ~pkt_rdy;  // blocked, hold everything

  a_data_hold: assert property (@(posedge clk) disable iff (rst)
    busy |=> $stable(pkt_data));

endmodule

// ==== spinn_rx/pkt_assembler.sv ====
// pkt_assembler: shifts decoded nibbles into the packet buffer and aligns short or long frames
module pkt_assembler (
  input  logic               clk,
  input  logic               rst,
  input  spinn_rx_pkg::sym_t sym,
  input  logic               shift_en,
  input  logic               first,
  output spinn_rx_pkg::pkt_t frame,
  output logic               exp_eop
);
  import spinn_rx_pkg::*;

  pkt_t     pkt_buf;   // newest nibble at the top
  sym_cnt_t sym_cnt;
  logic     long_pkt;  // bit 1 of the opening nibble

  // ------------------------------
  // shift buffer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (shift_en)
      pkt_buf <= {sym.val, pkt_buf[PKT_BITS-1:4]};
  end

  // count and length flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sym_cnt  <= '0;
      long_pkt <= 1'b0;
    end else if (shift_en) begin
      if (first) begin
        sym_cnt  <= sym_cnt_t'(1);  // restart on a new packet
        long_pkt <= sym.val[1];
      end else begin
        sym_cnt <= sym_cnt + 1'b1;
      end
    end
  end

  // eop is only good at the exact length
  assign exp_eop = long_pkt ? (sym_cnt == LONG_SYMS) : (sym_cnt == SHORT_SYMS);

  // ------------------------------
  // frame alignment
  // ------------------------------
  // short packet sits in the top 40 bits, move it down, zero fill
  always_comb begin
    if (long_pkt)
      frame = pkt_buf;
    else
      frame = {32'd0, pkt_buf[PKT_BITS-1 -: 40]};
  end

  // controller must stop shifting at the long length
  a_cnt_max: assert property (@(posedge clk) disable iff (rst)
    shift_en |-> sym_cnt <= LONG_SYMS);

endmodule

// ==== spinn_rx/nrz_2of7_decoder.sv ====
// nrz_2of7_decoder: classifies NRZ 2-of-7 wire changes and drives the two-phase link ack
module nrz_2of7_decoder (
  input  logic                clk,
  input  logic                rst,
  input  spinn_rx_pkg::link_t data_2of7,
  input  logic                sym_take,
  input  logic                link_init,
  output spinn_rx_pkg::sym_t  sym,
  output logic                ack
);
  import spinn_rx_pkg::*;

  link_t prev_wires;  // wire levels at the last accepted symbol
  link_t diff;        // wires that toggled since then

  assign diff = data_2of7 ^ prev_wires;

  // ------------------------------
  // symbol classification
  // ------------------------------
  always_comb begin
    sym = '0;
    // zero or one wire changed, still arriving
    if ($countones(diff) > 1) begin
      sym.nsb = 1'b1;
      if (diff == EOP_CODE) begin
        sym.eop = 1'b1;
      end else begin
        sym.bad = 1'b1;  // cleared below on a table hit
        for (int i = 0; i < 16; i++) begin
          if (diff == DATA_CODE[i]) begin
            sym.dat = 1'b1;
            sym.bad = 1'b0;
            sym.val = nibble_t'(i);
          end
        end
      end
    end
  end

  // ------------------------------
  // wire memory and ack
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prev_wires <= '0;
      ack        <= 1'b0;
    end else if (link_init) begin
      prev_wires <= data_2of7;
      ack        <= 1'b1;  // sender sees a ready link after reset
    end else if (sym_take) begin
      prev_wires <= data_2of7;  // consume the symbol
      ack        <= ~ack;       // two-phase, one edge per symbol
    end
  end

  // only the controller moves the link handshake
  a_ack_strobe: assert property (@(posedge clk) disable iff (rst)
    !(sym_take || link_init) |=> $stable(ack));

endmodule

// ==== common/spinn_rx_pkg.sv ====
// spinn_rx_pkg: link code constants, symbol struct and packet types for the SpiNNaker receiver
package spinn_rx_pkg;

  // ------------------------------
  // frame geometry
  // ------------------------------
  localparam int PKT_BITS = 72;  // long packet, 18 nibbles

  typedef logic [4:0] sym_cnt_t;  // data symbols seen so far

  localparam sym_cnt_t SHORT_SYMS = 5'd10;  // 40-bit packet
  localparam sym_cnt_t LONG_SYMS  = 5'd18;  // 72-bit packet

  typedef logic [PKT_BITS-1:0] pkt_t;
  typedef logic [3:0]          nibble_t;

  // ------------------------------
  // link wires and 2-of-7 code
  // ------------------------------
  typedef logic [6:0] link_t;  // NRZ, one transition per wire

  // wires 5 and 6 changed
  localparam link_t EOP_CODE = 7'b110_0000;

  // transition pattern of each data nibble, index = nibble value
  localparam link_t DATA_CODE [16] = '{
    7'b001_0001,  // 0
    7'b001_0010,  // 1
    7'b001_0100,  // 2
    7'b001_1000,  // 3
    7'b010_0001,  // 4
    7'b010_0010,  // 5
    7'b010_0100,  // 6
    7'b010_1000,  // 7
    7'b100_0001,  // 8
    7'b100_0010,  // 9
    7'b100_0100,  // 10
    7'b100_1000,  // 11
    7'b000_0011,  // 12
    7'b000_0110,  // 13
    7'b000_1100,  // 14
    7'b000_1001   // 15
  };

  // decoder result handed to control and assembly
  typedef struct packed {
    logic    nsb;  // complete symbol on the wires
    logic    dat;  // data nibble
    logic    eop;  // end of packet
    logic    bad;  // two or more wires, not a legal code
    nibble_t val;  // only valid with dat
  } sym_t;

endpackage
